// File: rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int SETS           = 4;
    localparam int WAYS           = 2;
    localparam int LINE_BYTES     = 64;
    localparam int MEM_BEAT_W     = 128;
    localparam int BEATS_PER_LINE = 4;
    localparam int WORDS_PER_BEAT = 4;

    // address widths, core in words and memory in 16-byte beats
    localparam int CORE_ADDR_W  = 14;
    localparam int WORD_W       = $clog2(WORDS_PER_BEAT);
    localparam int MEM_ADDR_W   = CORE_ADDR_W - WORD_W;

    // address fields
    localparam int IDX_W        = $clog2(SETS);
    localparam int WAY_W        = $clog2(WAYS);
    localparam int BEAT_W       = $clog2(BEATS_PER_LINE);
    localparam int LINE_WORDS_W = $clog2(LINE_BYTES / 4);
    localparam int TAG_W        = CORE_ADDR_W - LINE_WORDS_W - IDX_W;
    localparam int BANK_ADDR_W  = IDX_W + BEAT_W;

    typedef enum logic [1:0] {
        RESET,
        READY,
        MISS
    } icache_state_t;

    typedef struct packed {
        logic                   valid;
        logic [CORE_ADDR_W-1:0] addr;
    } core_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } core_rsp_t;

    typedef struct packed {
        logic                  valid;
        logic [MEM_ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic                  valid;
        logic [MEM_BEAT_W-1:0] data;
    } mem_rsp_t;

    // missed request waiting on a refill
    typedef struct packed {
        logic                   active;
        logic [CORE_ADDR_W-1:0] addr;
        logic [WAY_W-1:0]       way;
        logic [MEM_ADDR_W-1:0]  mem_start;
    } pend_req_t;

    function automatic logic [TAG_W-1:0] tag_of(input logic [CORE_ADDR_W-1:0] addr);
        return addr[CORE_ADDR_W-1 -: TAG_W];
    endfunction

    function automatic logic [IDX_W-1:0] set_of(input logic [CORE_ADDR_W-1:0] addr);
        return addr[LINE_WORDS_W +: IDX_W];
    endfunction

    function automatic logic [BEAT_W-1:0] beat_of(input logic [CORE_ADDR_W-1:0] addr);
        return addr[WORD_W +: BEAT_W];
    endfunction

    function automatic logic [WORD_W-1:0] word_of(input logic [CORE_ADDR_W-1:0] addr);
        return addr[WORD_W-1:0];
    endfunction

endpackage

`default_nettype wire

// File: rtl/icache_bank.sv
`timescale 1ns/100ps
`default_nettype none

module icache_bank import icache_pkg::*; (
    input  logic                   clk,
    input  logic                   we_i,
    input  logic [BANK_ADDR_W-1:0] addr_i,
    input  logic [MEM_BEAT_W-1:0]  wdata_i,
    output logic [MEM_BEAT_W-1:0]  rdata_o
);

    // one entry per set and beat
    logic [MEM_BEAT_W-1:0] mem_q [2**BANK_ADDR_W];

    // read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
        rdata_o <= mem_q[addr_i];
    end

    a_wr_addr_known: assert property (@(posedge clk) we_i |-> !$isunknown(addr_i));

endmodule

`default_nettype wire

// File: rtl/icache_tag_store.sv
`timescale 1ns/100ps
`default_nettype none

module icache_tag_store import icache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [CORE_ADDR_W-1:0] lookup_addr_i,
    output logic                   hit_o,
    output logic [WAY_W-1:0]       hit_way_o,
    output logic [WAY_W-1:0]       victim_way_o,
    input  logic                   fill_i,
    input  logic [WAY_W-1:0]       fill_way_i,
    input  logic [IDX_W-1:0]       fill_set_i,
    input  logic [TAG_W-1:0]       fill_tag_i,
    input  logic                   inval_i,
    input  logic [WAY_W-1:0]       inval_way_i,
    input  logic [IDX_W-1:0]       inval_set_i,
    input  logic                   touch_i,
    input  logic [WAY_W-1:0]       touch_way_i,
    input  logic [IDX_W-1:0]       touch_set_i
);

    logic             valid_q [WAYS][SETS];
    logic [TAG_W-1:0] tag_q   [WAYS][SETS];
    logic [WAY_W-1:0] lru_q   [WAYS][SETS];

    logic [IDX_W-1:0] lookup_set;
    logic [TAG_W-1:0] lookup_tag;
    logic [WAYS-1:0]  match;
    logic [SETS-1:0]  lru_distinct;

    assign lookup_set = set_of(lookup_addr_i);
    assign lookup_tag = tag_of(lookup_addr_i);

    // tag compare against every way of the set
    always_comb begin
        hit_o        = 1'b0;
        hit_way_o    = '0;
        victim_way_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            match[w] = valid_q[w][lookup_set] && (tag_q[w][lookup_set] == lookup_tag);
            if (match[w]) begin
                hit_o     = 1'b1;
                hit_way_o = WAY_W'(w);
            end
            // oldest way goes out
            if (lru_q[w][lookup_set] == WAY_W'(WAYS - 1)) begin
                victim_way_o = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    valid_q[w][s] <= 1'b0;
                end
            end
        end else begin
            if (fill_i) begin
                valid_q[fill_way_i][fill_set_i] <= 1'b1;
            end
            if (inval_i) begin
                valid_q[inval_way_i][inval_set_i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[fill_way_i][fill_set_i] <= fill_tag_i;
        end
    end

    // touched way becomes newest, younger ones age by one
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    lru_q[w][s] <= WAY_W'(w);
                end
            end
        end else if (touch_i) begin
            for (int w = 0; w < WAYS; w++) begin
                if (lru_q[w][touch_set_i] < lru_q[touch_way_i][touch_set_i]) begin
                    lru_q[w][touch_set_i] <= lru_q[w][touch_set_i] + 1'b1;
                end
            end
            lru_q[touch_way_i][touch_set_i] <= '0;
        end
    end

    always_comb begin
        for (int s = 0; s < SETS; s++) begin
            lru_distinct[s] = 1'b1;
            for (int a = 0; a < WAYS; a++) begin
                for (int b = a + 1; b < WAYS; b++) begin
                    if (lru_q[a][s] == lru_q[b][s]) begin
                        lru_distinct[s] = 1'b0;
                    end
                end
            end
        end
    end

    a_one_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(match));

    a_lru_perm: assert property (@(posedge clk) disable iff (rst)
        touch_i |=> lru_distinct[$past(touch_set_i)]);

endmodule

`default_nettype wire

// File: rtl/icache_refill.sv
`timescale 1ns/100ps
`default_nettype none

module icache_refill import icache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  icache_state_t          state_i,
    input  logic                   save_i,
    input  logic [CORE_ADDR_W-1:0] save_addr_i,
    input  logic [WAY_W-1:0]       save_way_i,
    input  logic                   clear_i,
    input  logic                   spec_wrong_i,
    input  logic                   mem_rsp_valid_i,
    output pend_req_t              pend_o,
    output mem_req_t               mem_req_o,
    output logic [BEAT_W-1:0]      beat_o,
    output logic                   last_beat_o
);

    pend_req_t             pend_q;
    logic [BEAT_W-1:0]     req_cnt_q;
    logic [BEAT_W-1:0]     rsp_cnt_q;
    logic [MEM_ADDR_W-1:0] start_addr;
    logic                  req_more;
    logic                  beat_in;

    // first beat of the missed line
    assign start_addr = {save_addr_i[CORE_ADDR_W-1:LINE_WORDS_W], {BEAT_W{1'b0}}};

    // beat 0 leaves with the save, the rest while in MISS
    assign req_more = (state_i == MISS) && pend_q.active && (req_cnt_q != '0)
                      && !spec_wrong_i;
    assign beat_in  = mem_rsp_valid_i && pend_q.active && !spec_wrong_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_q <= '0;
        end else if (spec_wrong_i || clear_i) begin
            pend_q <= '0;
        end else if (save_i) begin
            pend_q.active    <= 1'b1;
            pend_q.addr      <= save_addr_i;
            pend_q.way       <= save_way_i;
            pend_q.mem_start <= start_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || spec_wrong_i) begin
            req_cnt_q <= '0;
            rsp_cnt_q <= '0;
        end else begin
            if (save_i || req_more) begin
                req_cnt_q <= req_cnt_q + 1'b1;
            end
            if (beat_in) begin
                rsp_cnt_q <= rsp_cnt_q + 1'b1;
            end
        end
    end

    always_comb begin
        mem_req_o = '0;
        if (save_i) begin
            mem_req_o.valid = 1'b1;
            mem_req_o.addr  = start_addr;
        end else if (req_more) begin
            mem_req_o.valid = 1'b1;
            mem_req_o.addr  = {pend_q.mem_start[MEM_ADDR_W-1:BEAT_W], req_cnt_q};
        end
    end

    assign pend_o      = pend_q;
    assign beat_o      = rsp_cnt_q;
    assign last_beat_o = beat_in && (rsp_cnt_q == BEAT_W'(BEATS_PER_LINE - 1));

    a_rsp_has_pend: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid_i |-> pend_q.active);

endmodule

`default_nettype wire

// File: rtl/icache.sv
`timescale 1ns/100ps
`default_nettype none

module icache import icache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      spec_wrong_i,
    input  core_req_t core_req_i,
    output logic      core_ready_o,
    output core_rsp_t core_rsp_o,
    output mem_req_t  mem_req_o,
    input  mem_rsp_t  mem_rsp_i,
    output logic      mem_rsp_ready_o
);

    icache_state_t state_q;
    icache_state_t state_d;

    core_req_t        req_q;
    logic             hit_q;
    logic [WAY_W-1:0] victim_q;
    logic             last_beat_q;

    logic             accept;
    logic             hit;
    logic [WAY_W-1:0] hit_way;
    logic [WAY_W-1:0] victim_way;
    logic             miss_start;
    logic             refill_done;
    logic             pend_rsp;

    pend_req_t         pend;
    logic [BEAT_W-1:0] fill_beat;
    logic              last_beat;

    logic                   bank_wr;
    logic [WAYS-1:0]        bank_we;
    logic [BANK_ADDR_W-1:0] bank_addr;
    logic [MEM_BEAT_W-1:0]  bank_rdata [WAYS];
    logic [WAY_W-1:0]       rd_way_q;
    logic [WORD_W-1:0]      rd_word_q;

    assign accept      = core_req_i.valid && (core_ready_o || spec_wrong_i);
    assign miss_start  = (state_q == READY) && req_q.valid && !hit_q && !spec_wrong_i;
    assign refill_done = (state_q == MISS) && last_beat_q && !spec_wrong_i;
    assign pend_rsp    = (state_q == READY) && pend.active;

    assign core_ready_o    = (state_q == READY) && !miss_start;
    assign mem_rsp_ready_o = (state_q == MISS) && pend.active && !last_beat_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= RESET;
            req_q.valid <= 1'b0;
            last_beat_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            req_q.valid <= accept;
            last_beat_q <= last_beat;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            RESET: state_d = READY;
            READY: begin
                if (miss_start) begin
                    state_d = MISS;
                end
            end
            // one extra cycle after the last beat to read the pending word
            MISS: begin
                if (spec_wrong_i || last_beat_q) begin
                    state_d = READY;
                end
            end
            default: state_d = RESET;
        endcase
    end

    // lookup result is registered with the request
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.addr <= core_req_i.addr;
            hit_q      <= hit;
            victim_q   <= victim_way;
        end
    end

    icache_tag_store tag_store_i (
        .clk           (clk),
        .rst           (rst),
        .lookup_addr_i (core_req_i.addr),
        .hit_o         (hit),
        .hit_way_o     (hit_way),
        .victim_way_o  (victim_way),
        .fill_i        (last_beat),
        .fill_way_i    (pend.way),
        .fill_set_i    (set_of(pend.addr)),
        .fill_tag_i    (tag_of(pend.addr)),
        .inval_i       (miss_start),
        .inval_way_i   (victim_q),
        .inval_set_i   (set_of(req_q.addr)),
        .touch_i       ((accept && hit) || refill_done),
        .touch_way_i   (refill_done ? pend.way : hit_way),
        .touch_set_i   (refill_done ? set_of(pend.addr) : set_of(core_req_i.addr))
    );

    icache_refill refill_i (
        .clk             (clk),
        .rst             (rst),
        .state_i         (state_q),
        .save_i          (miss_start),
        .save_addr_i     (req_q.addr),
        .save_way_i      (victim_q),
        .clear_i         (pend_rsp),
        .spec_wrong_i    (spec_wrong_i),
        .mem_rsp_valid_i (mem_rsp_i.valid),
        .pend_o          (pend),
        .mem_req_o       (mem_req_o),
        .beat_o          (fill_beat),
        .last_beat_o     (last_beat)
    );

    assign bank_wr = mem_rsp_i.valid && mem_rsp_ready_o && !spec_wrong_i;

    // refill writes first, then the pending read, else the new request
    always_comb begin
        if (bank_wr) begin
            bank_addr = {set_of(pend.addr), fill_beat};
        end else if ((state_q == MISS) && !spec_wrong_i) begin
            bank_addr = {set_of(pend.addr), beat_of(pend.addr)};
        end else begin
            bank_addr = {set_of(core_req_i.addr), beat_of(core_req_i.addr)};
        end
    end

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        assign bank_we[w] = bank_wr && (pend.way == WAY_W'(w));

        icache_bank bank_i (
            .clk     (clk),
            .we_i    (bank_we[w]),
            .addr_i  (bank_addr),
            .wdata_i (mem_rsp_i.data),
            .rdata_o (bank_rdata[w])
        );
    end

    // way and word for next cycle's response
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_way_q  <= hit_way;
            rd_word_q <= word_of(core_req_i.addr);
        end else if (state_q == MISS) begin
            rd_way_q  <= pend.way;
            rd_word_q <= word_of(pend.addr);
        end
    end

    always_comb begin
        core_rsp_o.valid = pend_rsp || ((state_q == READY) && req_q.valid && hit_q);
        core_rsp_o.data  = bank_rdata[rd_way_q][32*rd_word_q +: 32];
    end

    // a pending word is only answered right after its refill completes
    a_rsp_after_refill: assert property (@(posedge clk) disable iff (rst)
        pend_rsp |-> $past(refill_done));

    // line must split evenly into beats and words
    a_geometry: assert property (@(posedge clk)
        (BEATS_PER_LINE * MEM_BEAT_W == LINE_BYTES * 8)
        && (WORDS_PER_BEAT * 32 == MEM_BEAT_W)
        && (LINE_WORDS_W == BEAT_W + WORD_W)
        && ((SETS & (SETS - 1)) == 0));

endmodule

`default_nettype wire

// File: bench/icache_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module icache_mem_model import icache_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t mem_req_i,
    output mem_rsp_t mem_rsp_o
);

    logic [MEM_BEAT_W-1:0] beat_data;

    // word k of beat b lives at word address 4b+k
    always_comb begin
        for (int k = 0; k < WORDS_PER_BEAT; k++) begin
            beat_data[32*k +: 32] = (32'(mem_req_i.addr) * WORDS_PER_BEAT + 32'(k)) * 3
                                    + 32'h5A5A_0000;
        end
    end

    // always ready, answers one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_rsp_o <= '0;
        end else begin
            mem_rsp_o.valid <= mem_req_i.valid;
            mem_rsp_o.data  <= beat_data;
        end
    end

endmodule

`default_nettype wire

// File: bench/icache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module icache_tb import icache_pkg::*; ();

    localparam int TIMEOUT = 50;

    typedef enum logic [1:0] {
        EXP_MISS,
        EXP_HIT,
        EXP_ANY
    } outcome_t;

    typedef struct packed {
        logic [CORE_ADDR_W-1:0] addr;
        logic                   cancel;
        outcome_t               outcome;
        logic                   has_rsp;
    } entry_t;

    logic      clk;
    logic      rst;
    logic      spec_wrong;
    core_req_t core_req;
    logic      core_ready;
    core_rsp_t core_rsp;
    mem_req_t  mem_req;
    mem_rsp_t  mem_rsp;
    logic      mem_rsp_ready;

    int        cyc = 0;
    int        errors = 0;
    int        tests = 0;
    int        failed = 0;
    int        beats_taken = 0;
    entry_t    table_q[$];
    mem_req_t  seen_q[$];
    core_rsp_t rsp_q[$];
    int        rsp_cyc_q[$];

    icache dut_i (
        .clk             (clk),
        .rst             (rst),
        .spec_wrong_i    (spec_wrong),
        .core_req_i      (core_req),
        .core_ready_o    (core_ready),
        .core_rsp_o      (core_rsp),
        .mem_req_o       (mem_req),
        .mem_rsp_i       (mem_rsp),
        .mem_rsp_ready_o (mem_rsp_ready)
    );

    icache_mem_model mem_i (
        .clk       (clk),
        .rst       (rst),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && mem_req.valid === 1'b1) begin
            seen_q.push_back(mem_req);
        end
        if (!rst && core_rsp.valid === 1'b1) begin
            rsp_q.push_back(core_rsp);
            rsp_cyc_q.push_back(cyc);
        end
        // refill beats the DUT took in
        if (!rst && mem_rsp.valid === 1'b1 && mem_rsp_ready === 1'b1) begin
            beats_taken++;
        end
    end

    function automatic logic [31:0] mem_word(input int word_addr);
        return 32'(word_addr) * 3 + 32'h5A5A_0000;
    endfunction

    // beat address of beat n of the line holding addr
    function automatic logic [MEM_ADDR_W-1:0] line_beat(input logic [CORE_ADDR_W-1:0] addr,
                                                        input int n);
        return MEM_ADDR_W'((int'(addr) / (LINE_BYTES / 4)) * BEATS_PER_LINE + n);
    endfunction

    task automatic flag_error(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        errors++;
    endtask

    task automatic check_rsp(input string name, input core_rsp_t got, input core_rsp_t exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %b/%h exp %b/%h", $time, name,
                     got.valid, got.data, exp.valid, exp.data);
            errors++;
        end
    endtask

    task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %b/%h exp %b/%h", $time, name,
                     got.valid, got.addr, exp.valid, exp.addr);
            errors++;
        end
    endtask

    task automatic note_result(input string what, input int err_start);
        tests++;
        if (errors != err_start) begin
            failed++;
        end
        $display("test %0d %s: %s", tests, what, (errors == err_start) ? "ok" : "errors");
    endtask

    task automatic send_req(input logic [CORE_ADDR_W-1:0] addr, output int acc_cyc);
        int n;
        @(posedge clk);
        core_req <= {1'b1, addr};
        acc_cyc = -1;
        n = 0;
        while (acc_cyc < 0 && n < TIMEOUT) begin
            @(negedge clk);
            if (core_ready === 1'b1) begin
                acc_cyc = cyc;
            end
            n++;
        end
        if (acc_cyc < 0) begin
            flag_error($sformatf("request for %h never accepted", addr));
        end
    endtask

    task automatic drop_req();
        @(posedge clk);
        core_req <= '0;
    endtask

    task automatic wait_rsps(input int count);
        int n;
        n = 0;
        while (rsp_q.size() < count && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic check_reset();
        int n;
        int err_start;
        err_start = errors;
        n = 0;
        while (core_ready !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            if (core_rsp.valid !== 1'b0 || mem_req.valid !== 1'b0) begin
                flag_error("response or memory request while leaving reset");
            end
            if (core_ready !== 1'b1 && mem_rsp_ready !== 1'b0) begin
                flag_error("mem_rsp_ready_o high while leaving reset");
            end
            n++;
        end
        if (core_ready !== 1'b1) begin
            flag_error("core_ready_o never rose after reset");
        end
        note_result("reset", err_start);
    endtask

    task automatic run_entry(input entry_t e);
        int        acc_cyc;
        int        err_start;
        int        b;
        core_rsp_t exp_rsp;
        mem_req_t  exp_req;
        err_start = errors;
        seen_q.delete();
        rsp_q.delete();
        rsp_cyc_q.delete();
        beats_taken = 0;
        send_req(e.addr, acc_cyc);
        drop_req();
        // wrong path flagged one cycle into the miss
        if (e.cancel) begin
            @(posedge clk);
            spec_wrong <= 1'b1;
            @(posedge clk);
            spec_wrong <= 1'b0;
        end
        wait_rsps(1);
        if (!e.has_rsp) begin
            if (rsp_q.size() != 0) begin
                flag_error($sformatf("cancelled access to %h still answered", e.addr));
            end
            if (seen_q.size() == 0 || seen_q.size() >= BEATS_PER_LINE) begin
                flag_error($sformatf("cancelled miss issued %0d beat requests", seen_q.size()));
            end else begin
                exp_req = {1'b1, line_beat(e.addr, 0)};
                check_mem_req("mem_req_o", seen_q[0], exp_req);
            end
        end else if (rsp_q.size() == 0) begin
            flag_error($sformatf("no response for address %h", e.addr));
        end else begin
            exp_rsp = {1'b1, mem_word(e.addr)};
            check_rsp("core_rsp_o", rsp_q[0], exp_rsp);
            if (seen_q.size() == 0 && e.outcome != EXP_MISS) begin
                if (rsp_cyc_q[0] != acc_cyc + 1) begin
                    flag_error($sformatf("hit on %h answered %0d cycles after acceptance",
                                         e.addr, rsp_cyc_q[0] - acc_cyc));
                end
                if (beats_taken != 0) begin
                    flag_error($sformatf("hit on %h took %0d refill beats",
                                         e.addr, beats_taken));
                end
            end else if (seen_q.size() == BEATS_PER_LINE && e.outcome != EXP_HIT) begin
                for (b = 0; b < BEATS_PER_LINE; b++) begin
                    exp_req = {1'b1, line_beat(e.addr, b)};
                    check_mem_req("mem_req_o", seen_q[b], exp_req);
                end
                if (beats_taken != BEATS_PER_LINE) begin
                    flag_error($sformatf("refill of %h took %0d of %0d beats",
                                         e.addr, beats_taken, BEATS_PER_LINE));
                end
            end else begin
                flag_error($sformatf("%0d beat requests for address %h", seen_q.size(), e.addr));
            end
        end
        note_result($sformatf("addr %h", e.addr), err_start);
    endtask

    task automatic back_to_back(input logic [CORE_ADDR_W-1:0] a0,
                                input logic [CORE_ADDR_W-1:0] a1);
        int        acc0;
        int        acc1;
        int        err_start;
        core_rsp_t exp_rsp;
        err_start = errors;
        seen_q.delete();
        rsp_q.delete();
        rsp_cyc_q.delete();
        send_req(a0, acc0);
        send_req(a1, acc1);
        drop_req();
        wait_rsps(2);
        if (acc1 != acc0 + 1) begin
            flag_error("second hit not accepted in the following cycle");
        end
        if (rsp_q.size() != 2 || seen_q.size() != 0) begin
            flag_error($sformatf("%0d responses and %0d beat requests for two hits",
                                 rsp_q.size(), seen_q.size()));
        end else begin
            exp_rsp = {1'b1, mem_word(a0)};
            check_rsp("core_rsp_o", rsp_q[0], exp_rsp);
            exp_rsp = {1'b1, mem_word(a1)};
            check_rsp("core_rsp_o", rsp_q[1], exp_rsp);
            if (rsp_cyc_q[0] != acc0 + 1 || rsp_cyc_q[1] != acc1 + 1) begin
                flag_error("back-to-back hits not answered one cycle after acceptance");
            end
        end
        note_result("back-to-back hits", err_start);
    endtask

    task automatic queue_access(input logic [CORE_ADDR_W-1:0] addr, input outcome_t outcome);
        table_q.push_back({addr, 1'b0, outcome, 1'b1});
    endtask

    task automatic queue_cancel(input logic [CORE_ADDR_W-1:0] addr);
        table_q.push_back({addr, 1'b1, EXP_MISS, 1'b0});
    endtask

    initial begin
        logic [CORE_ADDR_W-1:0] r;
        int                     i;
        void'($urandom(93));
        rst        = 1'b1;
        spec_wrong = 1'b0;
        core_req   = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        check_reset();

        // word address bits: tag 13:6, set 5:4, word in line 3:0
        queue_access(14'h0100, EXP_MISS);
        queue_access(14'h0107, EXP_HIT);
        queue_access(14'h010F, EXP_HIT);
        // set 1, lines A, B, A again, then C evicts B
        queue_access(14'h0210, EXP_MISS);
        queue_access(14'h0310, EXP_MISS);
        queue_access(14'h0214, EXP_HIT);
        queue_access(14'h0410, EXP_MISS);
        queue_access(14'h0218, EXP_HIT);
        queue_access(14'h031C, EXP_MISS);
        // sets 2 and 3 leave the others alone
        queue_access(14'h0520, EXP_MISS);
        queue_access(14'h0630, EXP_MISS);
        queue_access(14'h0100, EXP_HIT);
        queue_access(14'h0524, EXP_HIT);
        queue_access(14'h0634, EXP_HIT);
        queue_access(14'h021C, EXP_HIT);
        // cancelled miss leaves the line out
        queue_cancel(14'h0730);
        queue_access(14'h0730, EXP_MISS);
        queue_access(14'h0735, EXP_HIT);
        queue_access(14'h0638, EXP_HIT);
        foreach (table_q[n]) begin
            run_entry(table_q[n]);
        end

        back_to_back(14'h0100, 14'h0105);

        // random lines, each followed by a hit in the same line
        table_q.delete();
        for (i = 0; i < 4; i++) begin
            r = CORE_ADDR_W'($urandom);
            queue_access(r, EXP_ANY);
            queue_access({r[CORE_ADDR_W-1:LINE_WORDS_W], LINE_WORDS_W'($urandom)}, EXP_HIT);
        end
        foreach (table_q[n]) begin
            run_entry(table_q[n]);
        end

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: icache.f
rtl/icache_pkg.sv
rtl/icache_bank.sv
rtl/icache_tag_store.sv
rtl/icache_refill.sv
rtl/icache.sv
bench/icache_mem_model.sv
bench/icache_tb.sv
